/* hw/compress_pkg.sv */
// Coefficients are assumed already reduced below MLKEM_Q; results stay unpacked in 12-bit lanes
`default_nettype none

package compress_pkg;

    // ML-KEM parameters
    localparam int MLKEM_K = 4;
    localparam int MLKEM_N = 256;
    localparam int MLKEM_Q = 3329;

    // Memory geometry
    localparam int COEFF_W        = 12;
    localparam int MEM_ADDR_W     = 10;
    localparam int MEM_DATA_W     = 48;
    localparam int MEM_DEPTH      = 1 << MEM_ADDR_W;
    localparam int COEFF_PER_WORD = MEM_DATA_W / COEFF_W;
    localparam int POLY_WORDS     = MLKEM_K * MLKEM_N / COEFF_PER_WORD;
    localparam logic [MEM_ADDR_W-1:0] POLY_LAST_OFS = MEM_ADDR_W'(POLY_WORDS - 1);

    // Compression arithmetic
    // Numerator x*2^d + q/2 stays below 2^23 for x < q and d <= 11
    localparam int CMP_HALF_Q      = MLKEM_Q / 2;
    localparam int CMP_NUM_W       = 23;
    localparam int CMP_RECIP_W     = 24;
    localparam int CMP_PROD_W      = CMP_NUM_W + CMP_RECIP_W;
    localparam int CMP_RECIP_SHIFT = 35;
    // ceil(2^35 / q), exact quotient for every numerator below 2^23
    localparam logic [CMP_RECIP_W-1:0] CMP_RECIP_M = 24'd10321340;

    typedef enum logic [2:0] {
        CMP_D1  = 3'd0,
        CMP_D4  = 3'd1,
        CMP_D5  = 3'd2,
        CMP_D10 = 3'd3,
        CMP_D11 = 3'd4
    } compress_mode_e;

    typedef enum logic {
        CMP_RD_IDLE,
        CMP_RD_MEM
    } cmp_read_state_e;

    typedef enum logic {
        CMP_WR_IDLE,
        CMP_WR_MEM
    } cmp_write_state_e;

    // Number of output bits d for a mode
    function automatic logic [3:0] cmp_mode_bits(compress_mode_e mode);
        logic [3:0] d;
        case (mode)
            CMP_D4:  d = 4'd4;
            CMP_D5:  d = 4'd5;
            CMP_D10: d = 4'd10;
            CMP_D11: d = 4'd11;
            default: d = 4'd1;
        endcase
        return d;
    endfunction

endpackage

`default_nettype wire

/* hw/compress_ctrl.sv */
// Run parameters are latched on the accepted cmp_enable; a strobe while busy is dropped
`timescale 1ns/1ps
`default_nettype none

module compress_ctrl
    import compress_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize,
    input  logic                  cmp_enable,
    input  logic [MEM_ADDR_W-1:0] src_base_addr,
    input  logic [MEM_ADDR_W-1:0] dest_base_addr,
    input  compress_mode_e        mode,
    input  logic                  ready,
    output logic                  rd_en,
    output logic [MEM_ADDR_W-1:0] rd_addr,
    output logic                  wr_en,
    output logic [MEM_ADDR_W-1:0] wr_addr,
    output compress_mode_e        mode_q,
    output logic                  done
);

    logic [MEM_ADDR_W-1:0] src_base_q;
    logic [MEM_ADDR_W-1:0] dest_base_q;
    logic                  last_rd;
    logic                  last_wr;
    logic                  rst_rd_addr;
    logic                  incr_rd_addr;
    logic                  rst_wr_addr;
    logic                  incr_wr_addr;
    logic                  run_start;

    cmp_read_state_e  read_fsm_ps, read_fsm_ns;
    cmp_write_state_e write_fsm_ps, write_fsm_ns;

    // Run parameters
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            src_base_q  <= '0;
            dest_base_q <= '0;
            mode_q      <= CMP_D1;
        end else if (zeroize) begin
            src_base_q  <= '0;
            dest_base_q <= '0;
            mode_q      <= CMP_D1;
        end else if (run_start) begin
            src_base_q  <= src_base_addr;
            dest_base_q <= dest_base_addr;
            mode_q      <= mode;
        end
    end

    // Source address counter, holds on the last word
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_addr <= '0;
        end else if (zeroize) begin
            rd_addr <= '0;
        end else if (rst_rd_addr) begin
            rd_addr <= src_base_addr;
        end else if (incr_rd_addr && !last_rd) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    // Destination address counter
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_addr <= '0;
        end else if (zeroize) begin
            wr_addr <= '0;
        end else if (rst_wr_addr) begin
            wr_addr <= dest_base_q;
        end else if (incr_wr_addr && !last_wr) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    always_comb begin
        last_rd = (rd_addr == MEM_ADDR_W'(src_base_q + POLY_LAST_OFS));
        last_wr = (wr_addr == MEM_ADDR_W'(dest_base_q + POLY_LAST_OFS));
        done    = (read_fsm_ps == CMP_RD_IDLE) && (write_fsm_ps == CMP_WR_IDLE);
        rd_en   = (read_fsm_ps == CMP_RD_MEM);
        wr_en   = (write_fsm_ps == CMP_WR_MEM);
        // Writes may still be pending after the reads end
        run_start = done && cmp_enable;
    end

    // Read FSM
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            read_fsm_ps <= CMP_RD_IDLE;
        end else if (zeroize) begin
            read_fsm_ps <= CMP_RD_IDLE;
        end else begin
            read_fsm_ps <= read_fsm_ns;
        end
    end

    always_comb begin
        read_fsm_ns  = read_fsm_ps;
        rst_rd_addr  = 1'b0;
        incr_rd_addr = 1'b0;
        case (read_fsm_ps)
            CMP_RD_IDLE: begin
                rst_rd_addr = 1'b1;
                if (run_start) begin
                    read_fsm_ns = CMP_RD_MEM;
                end
            end
            CMP_RD_MEM: begin
                incr_rd_addr = 1'b1;
                if (last_rd) begin
                    read_fsm_ns = CMP_RD_IDLE;
                end
            end
            default: read_fsm_ns = CMP_RD_IDLE;
        endcase
    end

    // Write FSM, started by the first result from the unit
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            write_fsm_ps <= CMP_WR_IDLE;
        end else if (zeroize) begin
            write_fsm_ps <= CMP_WR_IDLE;
        end else begin
            write_fsm_ps <= write_fsm_ns;
        end
    end

    always_comb begin
        write_fsm_ns = write_fsm_ps;
        rst_wr_addr  = 1'b0;
        incr_wr_addr = 1'b0;
        case (write_fsm_ps)
            CMP_WR_IDLE: begin
                rst_wr_addr = 1'b1;
                if (ready && !done) begin
                    write_fsm_ns = CMP_WR_MEM;
                end
            end
            CMP_WR_MEM: begin
                incr_wr_addr = 1'b1;
                if (last_wr) begin
                    write_fsm_ns = CMP_WR_IDLE;
                end
            end
            default: write_fsm_ns = CMP_WR_IDLE;
        endcase
    end

    // Writes only start two cycles behind the first read
    a_wr_after_rd: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        $rose(wr_en) |-> $past(rd_en, 2));

    a_rd_in_run: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        rd_en |-> (MEM_ADDR_W'(rd_addr - src_base_q) <= POLY_LAST_OFS));

endmodule

`default_nettype wire

/* hw/compress_unit.sv */
// Lane inputs must be below q; each result sits in the low d bits of its 12-bit lane
`timescale 1ns/1ps
`default_nettype none

module compress_unit
    import compress_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize,
    input  logic                  rd_en,
    input  logic [MEM_DATA_W-1:0] rd_data,
    input  compress_mode_e        mode_q,
    output logic [MEM_DATA_W-1:0] wr_data,
    output logic                  ready
);

    logic                  rd_en_q;
    logic [3:0]            d;
    logic [COEFF_W-1:0]    d_mask;
    logic [MEM_DATA_W-1:0] cmp_word;

    always_comb begin
        d      = cmp_mode_bits(mode_q);
        d_mask = COEFF_W'((1 << d) - 1);
    end

    // One compressor per coefficient lane
    for (genvar i = 0; i < COEFF_PER_WORD; i++) begin : g_lane
        logic [COEFF_W-1:0]    coeff;
        logic [CMP_NUM_W-1:0]  num;
        logic [CMP_PROD_W-1:0] prod;
        logic [COEFF_W-1:0]    quot;

        assign coeff = rd_data[i*COEFF_W +: COEFF_W];
        // x*2^d + q/2
        assign num   = (CMP_NUM_W'(coeff) << d) + CMP_NUM_W'(CMP_HALF_Q);
        // Divide by q through the scaled reciprocal
        assign prod  = CMP_PROD_W'(num) * CMP_PROD_W'(CMP_RECIP_M);
        assign quot  = prod[CMP_RECIP_SHIFT +: COEFF_W];
        assign cmp_word[i*COEFF_W +: COEFF_W] = quot & d_mask;

        // Rounded quotient reaches at most 2^d, which the mask folds to zero
        a_lane_range: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
            rd_en_q |-> (quot <= (COEFF_W'(1) << d)));
    end

    // Read data arrives one cycle after rd_en
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_en_q <= 1'b0;
            ready   <= 1'b0;
        end else if (zeroize) begin
            rd_en_q <= 1'b0;
            ready   <= 1'b0;
        end else begin
            rd_en_q <= rd_en;
            // First read of a run
            ready   <= rd_en && !rd_en_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en_q) begin
            wr_data <= cmp_word;
        end
    end

endmodule

`default_nettype wire

/* hw/poly_mem.sv */
// Host and engine never share a cycle; ownership follows engine_busy with no arbitration
`timescale 1ns/1ps
`default_nettype none

module poly_mem
    import compress_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  rd_en,
    input  logic [MEM_ADDR_W-1:0] rd_addr,
    input  logic                  wr_en,
    input  logic [MEM_ADDR_W-1:0] wr_addr,
    input  logic [MEM_DATA_W-1:0] wr_data,
    input  logic                  host_we,
    input  logic                  host_re,
    input  logic [MEM_ADDR_W-1:0] host_addr,
    input  logic [MEM_DATA_W-1:0] host_wdata,
    input  logic                  engine_busy,
    output logic [MEM_DATA_W-1:0] rd_data,
    output logic [MEM_DATA_W-1:0] host_rdata
);

    logic [MEM_DATA_W-1:0] mem [MEM_DEPTH];
    logic [MEM_DATA_W-1:0] rd_q;
    logic                  mem_we;
    logic                  mem_re;
    logic [MEM_ADDR_W-1:0] mem_waddr;
    logic [MEM_ADDR_W-1:0] mem_raddr;
    logic [MEM_DATA_W-1:0] mem_wdata;

    // Port ownership
    always_comb begin
        if (engine_busy) begin
            mem_we    = wr_en;
            mem_waddr = wr_addr;
            mem_wdata = wr_data;
            mem_re    = rd_en;
            mem_raddr = rd_addr;
        end else begin
            mem_we    = host_we;
            mem_waddr = host_addr;
            mem_wdata = host_wdata;
            mem_re    = host_re;
            mem_raddr = host_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
        if (mem_re) begin
            rd_q <= mem[mem_raddr];
        end
    end

    assign rd_data    = rd_q;
    assign host_rdata = rd_q;

    a_no_host_when_busy: assert property (@(posedge clk) disable iff (!reset_n)
        engine_busy |-> !(host_we || host_re));

endmodule

`default_nettype wire

/* hw/compress_top.sv */
// Host may touch the memory only while done is high; cmp_enable is sampled only then
`timescale 1ns/1ps
`default_nettype none

module compress_top
    import compress_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize,
    input  logic                  cmp_enable,
    input  logic [MEM_ADDR_W-1:0] src_base_addr,
    input  logic [MEM_ADDR_W-1:0] dest_base_addr,
    input  compress_mode_e        mode,
    input  logic                  host_we,
    input  logic                  host_re,
    input  logic [MEM_ADDR_W-1:0] host_addr,
    input  logic [MEM_DATA_W-1:0] host_wdata,
    output logic [MEM_DATA_W-1:0] host_rdata,
    output logic                  done
);

    logic                  rd_en;
    logic [MEM_ADDR_W-1:0] rd_addr;
    logic                  wr_en;
    logic [MEM_ADDR_W-1:0] wr_addr;
    logic [MEM_DATA_W-1:0] rd_data;
    logic [MEM_DATA_W-1:0] wr_data;
    logic                  ready;
    logic                  engine_busy;
    compress_mode_e        mode_q;

    assign engine_busy = !done;

    compress_ctrl ctrl_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .cmp_enable     (cmp_enable),
        .src_base_addr  (src_base_addr),
        .dest_base_addr (dest_base_addr),
        .mode           (mode),
        .ready          (ready),
        .rd_en          (rd_en),
        .rd_addr        (rd_addr),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .mode_q         (mode_q),
        .done           (done)
    );

    compress_unit unit_i (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .mode_q  (mode_q),
        .wr_data (wr_data),
        .ready   (ready)
    );

    poly_mem mem_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .host_we     (host_we),
        .host_re     (host_re),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .engine_busy (engine_busy),
        .rd_data     (rd_data),
        .host_rdata  (host_rdata)
    );

endmodule

`default_nettype wire

/* tb/tb_compress_model.svh */
// Reference compression by plain integer division; lanes must hold values below q
`ifndef TB_COMPRESS_MODEL_SVH
`define TB_COMPRESS_MODEL_SVH

// Copy of every word the host has written or a run has produced
logic [MEM_DATA_W-1:0] mirror [MEM_DEPTH];

function automatic int mode_to_bits(compress_mode_e m);
    int d;
    case (m)
        CMP_D1:  d = 1;
        CMP_D4:  d = 4;
        CMP_D5:  d = 5;
        CMP_D10: d = 10;
        default: d = 11;
    endcase
    return d;
endfunction

// floor((x*2^d + q/2) / q) mod 2^d
function automatic int compress_coeff(int x, int d);
    int num;
    num = x * (1 << d) + MLKEM_Q / 2;
    return (num / MLKEM_Q) % (1 << d);
endfunction

function automatic logic [MEM_DATA_W-1:0] compress_word(logic [MEM_DATA_W-1:0] w,
                                                        compress_mode_e m);
    logic [MEM_DATA_W-1:0] r;
    int                    d;
    int                    x;
    d = mode_to_bits(m);
    r = '0;
    for (int i = 0; i < COEFF_PER_WORD; i++) begin
        x = int'(w[i*COEFF_W +: COEFF_W]);
        r[i*COEFF_W +: COEFF_W] = COEFF_W'(compress_coeff(x, d));
    end
    return r;
endfunction

`endif

/* tb/tb_compress_top.sv */
// Host accesses only while done is high; the run stops at the first mismatch or timeout
`timescale 1ns/1ps
`default_nettype none

module tb_compress_top
    import compress_pkg::*;
();

    localparam int          TIMEOUT_CYCLES = 400;
    localparam logic [31:0] SEED           = 32'h5595_f161;

    logic                  clk;
    logic                  reset_n;
    logic                  zeroize;
    logic                  cmp_enable;
    logic [MEM_ADDR_W-1:0] src_base_addr;
    logic [MEM_ADDR_W-1:0] dest_base_addr;
    compress_mode_e        mode;
    logic                  host_we;
    logic                  host_re;
    logic [MEM_ADDR_W-1:0] host_addr;
    logic [MEM_DATA_W-1:0] host_wdata;
    logic [MEM_DATA_W-1:0] host_rdata;
    logic                  done;

    `include "tb_compress_model.svh"

    compress_top dut_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .cmp_enable     (cmp_enable),
        .src_base_addr  (src_base_addr),
        .dest_base_addr (dest_base_addr),
        .mode           (mode),
        .host_we        (host_we),
        .host_re        (host_re),
        .host_addr      (host_addr),
        .host_wdata     (host_wdata),
        .host_rdata     (host_rdata),
        .done           (done)
    );

    always #5 clk = ~clk;

    // Every task starts and ends 1 ns after a rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic end_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic compare_word(input logic [MEM_DATA_W-1:0] actual,
                                input logic [MEM_DATA_W-1:0] expected, input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %h expected %h",
                     $time, what, actual, expected);
            end_with_failure();
        end
    endtask

    task automatic compare_done(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, done is %b expected %b",
                     $time, what, actual, expected);
            end_with_failure();
        end
    endtask

    function automatic logic [MEM_DATA_W-1:0] random_word();
        logic [MEM_DATA_W-1:0] w;
        for (int i = 0; i < COEFF_PER_WORD; i++) begin
            w[i*COEFF_W +: COEFF_W] = COEFF_W'($urandom % MLKEM_Q);
        end
        return w;
    endfunction

    function automatic compress_mode_e pick_mode(input int idx);
        compress_mode_e m;
        case (idx)
            0:       m = CMP_D1;
            1:       m = CMP_D4;
            2:       m = CMP_D5;
            3:       m = CMP_D10;
            default: m = CMP_D11;
        endcase
        return m;
    endfunction

    task automatic host_write(input logic [MEM_ADDR_W-1:0] addr,
                              input logic [MEM_DATA_W-1:0] data);
        host_we    = 1'b1;
        host_addr  = addr;
        host_wdata = data;
        mirror[addr] = data;
        next_cycle();
        host_we = 1'b0;
    endtask

    // Data is valid one cycle after host_re
    task automatic host_read(input logic [MEM_ADDR_W-1:0] addr,
                             output logic [MEM_DATA_W-1:0] data);
        host_re   = 1'b1;
        host_addr = addr;
        next_cycle();
        host_re = 1'b0;
        data    = host_rdata;
    endtask

    task automatic load_source(input logic [MEM_ADDR_W-1:0] base);
        for (int i = 0; i < POLY_WORDS; i++) begin
            host_write(MEM_ADDR_W'(base + i), random_word());
        end
    endtask

    task automatic check_source(input logic [MEM_ADDR_W-1:0] base);
        logic [MEM_DATA_W-1:0] got;
        logic [MEM_ADDR_W-1:0] addr;
        for (int i = 0; i < POLY_WORDS; i++) begin
            addr = MEM_ADDR_W'(base + i);
            host_read(addr, got);
            compare_word(got, mirror[addr], $sformatf("source word at %0d", addr));
        end
    endtask

    task automatic check_results(input logic [MEM_ADDR_W-1:0] src,
                                 input logic [MEM_ADDR_W-1:0] dest, input compress_mode_e m);
        logic [MEM_DATA_W-1:0] got;
        logic [MEM_DATA_W-1:0] exp;
        logic [MEM_ADDR_W-1:0] addr;
        for (int i = 0; i < POLY_WORDS; i++) begin
            addr = MEM_ADDR_W'(dest + i);
            exp  = compress_word(mirror[MEM_ADDR_W'(src + i)], m);
            host_read(addr, got);
            compare_word(got, exp, $sformatf("result word at %0d, mode %s", addr, m.name()));
            mirror[addr] = exp;
        end
    endtask

    task automatic wait_done(input string what);
        int cycles;
        cycles = 0;
        while (!done) begin
            if (cycles == TIMEOUT_CYCLES) begin
                $display("Timeout: done stayed low for %0d cycles during %s", cycles, what);
                end_with_failure();
            end else begin
                next_cycle();
                cycles++;
            end
        end
    endtask

    task automatic start_run(input logic [MEM_ADDR_W-1:0] src,
                             input logic [MEM_ADDR_W-1:0] dest, input compress_mode_e m);
        compare_done(done, 1'b1, "engine idle before start");
        src_base_addr  = src;
        dest_base_addr = dest;
        mode           = m;
        cmp_enable     = 1'b1;
        next_cycle();
        cmp_enable = 1'b0;
        compare_done(done, 1'b0, "done low after cmp_enable");
    endtask

    task automatic run_and_check(input logic [MEM_ADDR_W-1:0] src,
                                 input logic [MEM_ADDR_W-1:0] dest, input compress_mode_e m);
        start_run(src, dest, m);
        wait_done("compression run");
        check_results(src, dest, m);
        check_source(src);
    endtask

    initial begin
        logic [MEM_ADDR_W-1:0] src;
        logic [MEM_ADDR_W-1:0] dest;
        clk            = 1'b0;
        reset_n        = 1'b0;
        zeroize        = 1'b0;
        cmp_enable     = 1'b0;
        src_base_addr  = '0;
        dest_base_addr = '0;
        mode           = CMP_D1;
        host_we        = 1'b0;
        host_re        = 1'b0;
        host_addr      = '0;
        host_wdata     = '0;
        void'($urandom(SEED));
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;
        next_cycle();
        compare_done(done, 1'b1, "done after reset");

        // Host write and readback
        load_source(MEM_ADDR_W'(0));
        check_source(MEM_ADDR_W'(0));

        // All five modes
        for (int m = 0; m < 5; m++) begin
            load_source(MEM_ADDR_W'(0));
            run_and_check(MEM_ADDR_W'(0), MEM_ADDR_W'(256), pick_mode(m));
        end

        // Second strobe mid-run with other parameters
        load_source(MEM_ADDR_W'(0));
        start_run(MEM_ADDR_W'(0), MEM_ADDR_W'(512), CMP_D5);
        idle_cycles(50);
        src_base_addr  = MEM_ADDR_W'(300);
        dest_base_addr = MEM_ADDR_W'(700);
        mode           = CMP_D11;
        cmp_enable     = 1'b1;
        next_cycle();
        cmp_enable = 1'b0;
        // Third strobe once reads have ended but the last writes are pending
        idle_cycles(205);
        cmp_enable = 1'b1;
        next_cycle();
        cmp_enable = 1'b0;
        next_cycle();
        compare_done(done, 1'b1, "done at the end of the run with repeated strobes");
        check_results(MEM_ADDR_W'(0), MEM_ADDR_W'(512), CMP_D5);
        check_source(MEM_ADDR_W'(0));

        // Zeroize mid-run, then a clean run
        load_source(MEM_ADDR_W'(128));
        start_run(MEM_ADDR_W'(128), MEM_ADDR_W'(640), CMP_D10);
        idle_cycles(100);
        zeroize = 1'b1;
        next_cycle();
        compare_done(done, 1'b1, "done right after zeroize");
        zeroize = 1'b0;
        run_and_check(MEM_ADDR_W'(128), MEM_ADDR_W'(640), CMP_D10);

        // Random bases, regions may wrap but never overlap
        repeat (4) begin
            src  = MEM_ADDR_W'($urandom);
            dest = MEM_ADDR_W'(src + POLY_WORDS + ($urandom % (MEM_DEPTH - 2*POLY_WORDS + 1)));
            load_source(src);
            run_and_check(src, dest, pick_mode(int'($urandom % 5)));
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+tb
hw/compress_pkg.sv
hw/compress_ctrl.sv
hw/compress_unit.sv
hw/poly_mem.sv
hw/compress_top.sv
tb/tb_compress_top.sv

/* run.sh */
#!/bin/sh
# Compiles the testbench with Verilator and runs it; the exit status is the test result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module tb_compress_top -o sim_tb
./obj_dir/sim_tb
